//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_rip_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Test OK$$"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
rip_pkg.sv
rip_run_ctrl.sv
rip_fetch.sv
rip_decode.sv
rip_regfile.sv
rip_execute.sv
rip_mem_wb.sv
rip_core.sv
tb_rip_core.sv

//--- rip_core.sv
`timescale 1ns/1ps
`default_nettype none

module rip_core
    import rip_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  logic                   prog_we,
    input  logic [IMEM_ADDR_W-1:0] prog_addr,
    input  word_t                  prog_data,
    output logic                   busy,
    output word_t                  gp_value
);

    logic    pipe_rst_n;
    logic    halt_done;
    word_t   inst;
    word_t   inst_pc;
    logic    inst_valid;
    reg_num_t rs1_num;
    reg_num_t rs2_num;
    word_t   rs1_val;
    word_t   rs2_val;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     wb;
    logic    redirect;
    word_t   redirect_pc;
    logic [DMEM_ADDR_W-1:0] dmem_addr;
    logic    dmem_we;
    logic    dmem_re;
    word_t   dmem_wdata;

    rip_run_ctrl run_ctrl (
        .clk(clk), .rst_n(rst_n), .run(run), .halt_done(halt_done),
        .busy(busy), .pipe_rst_n(pipe_rst_n)
    );

    rip_fetch fetch (
        .clk(clk), .pipe_rst_n(pipe_rst_n),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid)
    );

    // a taken flow kills both younger stages
    rip_decode decode (
        .clk(clk), .pipe_rst_n(pipe_rst_n),
        .inst(inst), .inst_pc(inst_pc), .inst_valid(inst_valid), .flush(redirect),
        .rs1_num(rs1_num), .rs2_num(rs2_num), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .id_ex(id_ex)
    );

    rip_regfile regfile (
        .clk(clk), .rs1_num(rs1_num), .rs2_num(rs2_num),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .wb(wb), .gp_value(gp_value)
    );

    rip_execute execute (
        .clk(clk), .pipe_rst_n(pipe_rst_n), .id_ex(id_ex), .wb(wb),
        .redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wdata(dmem_wdata), .dmem_re(dmem_re)
    );

    rip_mem_wb mem_wb (
        .clk(clk), .ex_mem(ex_mem),
        .dmem_addr(dmem_addr), .dmem_we(dmem_we), .dmem_wdata(dmem_wdata), .dmem_re(dmem_re),
        .wb(wb), .halt_done(halt_done)
    );

endmodule

`default_nettype wire

//--- rip_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rip_decode
    import rip_pkg::*;
(
    input  logic     clk,
    input  logic     pipe_rst_n,
    input  word_t    inst,
    input  word_t    inst_pc,
    input  logic     inst_valid,
    input  logic     flush,
    output reg_num_t rs1_num,
    output reg_num_t rs2_num,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output id_ex_t   id_ex
);

    opcode_e opcode;
    ctrl_t   ctrl;
    word_t   imm;

    // shared by OP and OP-IMM, alt picks sub/sra
    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode  = opcode_e'(inst[6:0]);
    assign rs1_num = inst[19:15];
    assign rs2_num = inst[24:20];

    always_comb begin
        // anything not listed decodes as a no-op
        ctrl = '{alu_op: ALU_ADD, use_imm: 1'b0, reg_we: 1'b0, mem_read: 1'b0,
                 mem_write: 1'b0, flow: FLOW_NONE};
        imm  = {{20{inst[31]}}, inst[31:20]};
        case (opcode)
            OPC_LUI: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                imm          = {inst[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                ctrl.alu_op  = alu_sel(inst[14:12], inst[30] && inst[14:12] == 3'b101);
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_op = alu_sel(inst[14:12], inst[30]);
                ctrl.reg_we = 1'b1;
            end
            OPC_LOAD: begin
                if (inst[14:12] == 3'b010) begin
                    ctrl.use_imm  = 1'b1;
                    ctrl.reg_we   = 1'b1;
                    ctrl.mem_read = 1'b1;
                end
            end
            OPC_STORE: begin
                if (inst[14:12] == 3'b010) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OPC_BRANCH: begin
                case (inst[14:12])
                    3'b000:  ctrl.flow = FLOW_BEQ;
                    3'b001:  ctrl.flow = FLOW_BNE;
                    3'b100:  ctrl.flow = FLOW_BLT;
                    3'b101:  ctrl.flow = FLOW_BGE;
                    default: ctrl.flow = FLOW_NONE;
                endcase
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl.flow   = FLOW_JAL;
                ctrl.reg_we = 1'b1;
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl.flow   = FLOW_JALR;
                ctrl.reg_we = 1'b1;
            end
            OPC_SYSTEM: begin
                if (inst == INST_EBREAK) ctrl.flow = FLOW_HALT;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex.pc      <= inst_pc;
        id_ex.ctrl    <= ctrl;
        id_ex.rs1     <= rs1_num;
        id_ex.rs2     <= rs2_num;
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.imm     <= imm;
        id_ex.rd      <= inst[11:7];
        if (!pipe_rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= inst_valid && !flush;
        end
    end

endmodule

`default_nettype wire

//--- rip_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rip_execute
    import rip_pkg::*;
(
    input  logic                   clk,
    input  logic                   pipe_rst_n,
    input  id_ex_t                 id_ex,
    input  wb_t                    wb,
    output logic                   redirect,
    output word_t                  redirect_pc,
    output ex_mem_t                ex_mem,
    output logic [DMEM_ADDR_W-1:0] dmem_addr,
    output logic                   dmem_we,
    output word_t                  dmem_wdata,
    output logic                   dmem_re
);

    word_t src_a;
    word_t src_b;
    word_t op_b;
    word_t alu_out;
    word_t result;
    logic  taken;

    // forward from memory/writeback, older values came through the regfile bypass
    assign src_a = (wb.we && wb.rd != '0 && wb.rd == id_ex.rs1) ? wb.data : id_ex.rs1_val;
    assign src_b = (wb.we && wb.rd != '0 && wb.rd == id_ex.rs2) ? wb.data : id_ex.rs2_val;
    assign op_b  = id_ex.ctrl.use_imm ? id_ex.imm : src_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    alu_out = src_a - op_b;
            ALU_AND:    alu_out = src_a & op_b;
            ALU_OR:     alu_out = src_a | op_b;
            ALU_XOR:    alu_out = src_a ^ op_b;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, src_a < op_b};
            ALU_SLL:    alu_out = src_a << op_b[4:0];
            ALU_SRL:    alu_out = src_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(src_a) >>> op_b[4:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = src_a + op_b;
        endcase
    end

    always_comb begin
        case (id_ex.ctrl.flow)
            FLOW_BEQ: taken = (src_a == src_b);
            FLOW_BNE: taken = (src_a != src_b);
            FLOW_BLT: taken = ($signed(src_a) < $signed(src_b));
            FLOW_BGE: taken = ($signed(src_a) >= $signed(src_b));
            FLOW_JAL, FLOW_JALR, FLOW_HALT: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    // halt spins on itself so nothing younger commits
    always_comb begin
        case (id_ex.ctrl.flow)
            FLOW_HALT: redirect_pc = id_ex.pc;
            FLOW_JALR: redirect_pc = (src_a + id_ex.imm) & ~word_t'(1);
            default:   redirect_pc = id_ex.pc + id_ex.imm;
        endcase
    end

    assign redirect = id_ex.valid && taken;

    // links write pc+4
    assign result = (id_ex.ctrl.flow == FLOW_JAL || id_ex.ctrl.flow == FLOW_JALR) ?
                    id_ex.pc + 32'd4 : alu_out;

    assign dmem_addr  = alu_out[DMEM_ADDR_W+1:2];
    assign dmem_we    = id_ex.valid && id_ex.ctrl.mem_write;
    assign dmem_re    = id_ex.valid && id_ex.ctrl.mem_read;
    assign dmem_wdata = src_b;

    always_ff @(posedge clk) begin
        ex_mem.ctrl   <= id_ex.ctrl;
        ex_mem.rd     <= id_ex.rd;
        ex_mem.result <= result;
        if (!pipe_rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

endmodule

`default_nettype wire

//--- rip_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rip_fetch
    import rip_pkg::*;
(
    input  logic                   clk,
    input  logic                   pipe_rst_n,
    input  logic                   prog_we,
    input  logic [IMEM_ADDR_W-1:0] prog_addr,
    input  word_t                  prog_data,
    input  logic                   redirect,
    input  word_t                  redirect_pc,
    output word_t                  inst,
    output word_t                  inst_pc,
    output logic                   inst_valid
);

    word_t imem [IMEM_DEPTH];
    word_t pc;

    // program load only while the pipeline is held empty
    always_ff @(posedge clk) begin
        if (prog_we && !pipe_rst_n) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // synchronous read, word at pc shows up next cycle
    always_ff @(posedge clk) begin
        inst    <= imem[pc[IMEM_ADDR_W+1:2]];
        inst_pc <= pc;
    end

    always_ff @(posedge clk) begin
        if (!pipe_rst_n) begin
            pc         <= '0;
            inst_valid <= 1'b0;
        end else if (redirect) begin
            // word being read now is on the wrong path
            pc         <= redirect_pc;
            inst_valid <= 1'b0;
        end else begin
            pc         <= pc + 32'd4;
            inst_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rip_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module rip_mem_wb
    import rip_pkg::*;
(
    input  logic                   clk,
    input  ex_mem_t                ex_mem,
    input  logic [DMEM_ADDR_W-1:0] dmem_addr,
    input  logic                   dmem_we,
    input  word_t                  dmem_wdata,
    input  logic                   dmem_re,
    output wb_t                    wb,
    output logic                   halt_done
);

    word_t dmem [DMEM_DEPTH];
    word_t load_data;

    // access issued by execute, completes on this edge
    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
        if (dmem_re) begin
            load_data <= dmem[dmem_addr];
        end
    end

    assign wb.we   = ex_mem.valid && ex_mem.ctrl.reg_we;
    assign wb.rd   = ex_mem.rd;
    assign wb.data = ex_mem.ctrl.mem_read ? load_data : ex_mem.result;

    // all older work has written back by now
    assign halt_done = ex_mem.valid && (ex_mem.ctrl.flow == FLOW_HALT);

endmodule

`default_nettype wire

//--- rip_pkg.sv
`default_nettype none

package rip_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_DEPTH  = 64;
    localparam int DMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_DEPTH);
    localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_num_t;

    // the only SYSTEM encoding the core accepts
    localparam word_t INST_EBREAK = 32'h0010_0073;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        FLOW_NONE, FLOW_BEQ, FLOW_BNE, FLOW_BLT, FLOW_BGE, FLOW_JAL, FLOW_JALR, FLOW_HALT
    } flow_e;

    typedef enum logic {
        RUN_IDLE,
        RUN_ACTIVE
    } run_state_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_we;
        logic    mem_read;
        logic    mem_write;
        flow_e   flow;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        ctrl_t    ctrl;
        reg_num_t rs1;
        reg_num_t rs2;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_num_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_num_t rd;
        word_t    result;
    } ex_mem_t;

    // regfile write port, also the forwarding source
    typedef struct packed {
        logic     we;
        reg_num_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

//--- rip_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rip_regfile
    import rip_pkg::*;
(
    input  logic     clk,
    input  reg_num_t rs1_num,
    input  reg_num_t rs2_num,
    output word_t    rs1_val,
    output word_t    rs2_val,
    input  wb_t      wb,
    output word_t    gp_value
);

    // x0 is never written
    word_t regs [32];

    function automatic word_t read_port(input reg_num_t num);
        word_t val;
        if (num == '0) begin
            val = '0;
        end else if (wb.we && wb.rd == num) begin
            // same-cycle write is visible to decode
            val = wb.data;
        end else begin
            val = regs[num];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rs1_val = read_port(rs1_num);
        rs2_val = read_port(rs2_num);
    end

    assign gp_value = regs[3];

endmodule

`default_nettype wire

//--- rip_run_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rip_run_ctrl
    import rip_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic halt_done,
    output logic busy,
    output logic pipe_rst_n
);

    run_state_e state;
    run_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            RUN_IDLE:   if (run) state_next = RUN_ACTIVE;
            RUN_ACTIVE: if (halt_done) state_next = RUN_IDLE;
            default:    state_next = RUN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RUN_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy = (state == RUN_ACTIVE);
    // stages stay empty whenever the core is idle
    assign pipe_rst_n = rst_n && busy;

endmodule

`default_nettype wire

//--- tb_rip_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rip_core
    import rip_pkg::*;
();

    localparam int         WAIT_LIMIT  = 2000;
    localparam logic [6:0] OP_IMM      = 7'b0010011;
    localparam logic [6:0] LOAD_OPC    = 7'b0000011;
    localparam logic [6:0] JALR_OPC    = 7'b1100111;
    localparam word_t      EBREAK_INST = 32'h0010_0073;

    logic                   clk;
    logic                   rst_n;
    logic                   run;
    logic                   prog_we;
    logic [IMEM_ADDR_W-1:0] prog_addr;
    word_t                  prog_data;
    logic                   busy;
    word_t                  gp_value;

    word_t program_q[$];
    word_t rng;

    rip_core uut (
        .clk(clk), .rst_n(rst_n), .run(run),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .busy(busy), .gp_value(gp_value)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction formats
    function automatic word_t rtype(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t itype(input word_t imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t stype(input word_t imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t btype(input word_t imm, input int rs1, input int rs2,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t utype(input word_t upper, input int rd);
        return {upper[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t jtype(input word_t imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input word_t imm);
        return itype(imm, rs1, 3'b000, rd, OP_IMM);
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error %s: expected %b, actual %b", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < program_q.size(); i++) begin
            prog_we   = 1'b1;
            prog_addr = IMEM_ADDR_W'(i);
            prog_data = program_q[i];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
    endtask

    task automatic pulse_run();
        run = 1'b1;
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        int cycles = 0;
        while (busy !== level) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout waiting for busy to become %b", level);
                $display("Test FAILED");
                $fatal(1, "wait expired");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic run_program();
        pulse_run();
        wait_busy(1'b1);
        wait_busy(1'b0);
    endtask

    // x3 takes base plus start, then 7 more once x5 has counted down from 10
    task automatic countdown_program(input int base, input word_t start);
        program_q.delete();
        program_q.push_back(addi(3, base, start));
        program_q.push_back(addi(5, 0, 10));
        program_q.push_back(addi(5, 5, -1));
        program_q.push_back(btype(-4, 5, 0, 3'b001));
        program_q.push_back(addi(3, 3, 7));
        program_q.push_back(EBREAK_INST);
    endtask

    task automatic busy_control();
        check_bit("busy after reset", 1'b0, busy);
        countdown_program(0, 5);
        load_program();
        pulse_run();
        check_bit("busy one cycle after run", 1'b1, busy);
        wait_busy(1'b0);
        check_word("busy control first run", 32'd5 + 32'd7, gp_value);
        repeat (3) @(posedge clk);
        #1;
        check_bit("busy after halt", 1'b0, busy);
        // second program builds on the x3 left by the first
        countdown_program(3, 9);
        load_program();
        pulse_run();
        check_bit("busy on rerun", 1'b1, busy);
        repeat (6) @(posedge clk);
        #1;
        // a restart here would add 9 twice
        pulse_run();
        wait_busy(1'b0);
        check_word("busy control rerun", 32'd5 + 32'd7 + 32'd9 + 32'd7, gp_value);
    endtask

    task automatic alu_chain();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [4:0]  u;
        word_t       r1;
        word_t       r2;
        word_t       e;
        word_t       k;
        word_t       expected;
        for (int round = 0; round < 4; round++) begin
            rng = xorshift(rng);
            a   = rng[11:0];
            s   = rng[16:12];
            t   = rng[21:17];
            u   = rng[26:22];
            rng = xorshift(rng);
            b   = rng[11:0];
            c   = rng[23:12];
            r1  = sext12(a);
            r2  = sext12(b);
            e   = r1 + r2;
            e   = e ^ r1;
            e   = e | r2;
            e   = e & sext12(c);
            e   = e << s;
            e   = $signed(e) >>> t;
            e   = e >> u;
            k   = e - r1;
            expected = k + (($signed(k) < $signed(r2)) ? 32'd1 : 32'd0)
                         + ((r1 < k) ? 32'd1 : 32'd0);
            program_q.delete();
            program_q.push_back(addi(1, 0, r1));
            program_q.push_back(addi(2, 0, r2));
            program_q.push_back(rtype(7'b0000000, 2, 1, 3'b000, 4));
            program_q.push_back(rtype(7'b0000000, 1, 4, 3'b100, 4));
            program_q.push_back(rtype(7'b0000000, 2, 4, 3'b110, 4));
            program_q.push_back(itype(sext12(c), 4, 3'b111, 4, OP_IMM));
            program_q.push_back(itype({27'b0, s}, 4, 3'b001, 5, OP_IMM));
            program_q.push_back(itype({20'b0, 7'b0100000, t}, 5, 3'b101, 6, OP_IMM));
            program_q.push_back(itype({27'b0, u}, 6, 3'b101, 7, OP_IMM));
            program_q.push_back(rtype(7'b0100000, 1, 7, 3'b000, 8));
            program_q.push_back(rtype(7'b0000000, 2, 8, 3'b010, 9));
            program_q.push_back(rtype(7'b0000000, 8, 1, 3'b011, 10));
            program_q.push_back(rtype(7'b0000000, 9, 8, 3'b000, 3));
            program_q.push_back(rtype(7'b0000000, 10, 3, 3'b000, 3));
            program_q.push_back(EBREAK_INST);
            load_program();
            run_program();
            check_word($sformatf("alu chain round %0d", round), expected, gp_value);
        end
    endtask

    task automatic lui_constant();
        word_t k;
        word_t hi;
        for (int n = 0; n < 2; n++) begin
            rng = xorshift(rng);
            k   = (n == 0) ? 32'hdead_beef : rng;
            // round up so the signed low part lands back on k
            hi  = (k + 32'h800) >> 12;
            program_q.delete();
            program_q.push_back(utype(hi, 3));
            program_q.push_back(addi(3, 3, {20'b0, k[11:0]}));
            program_q.push_back(EBREAK_INST);
            load_program();
            run_program();
            check_word($sformatf("lui constant %0d", n), k, gp_value);
        end
    endtask

    task automatic store_load();
        word_t data;
        rng  = xorshift(rng);
        data = sext12(rng[11:0]);
        program_q.delete();
        program_q.push_back(addi(5, 0, 32'h123));
        program_q.push_back(addi(1, 0, data));
        program_q.push_back(addi(2, 0, 64));
        program_q.push_back(stype(8, 1, 2));
        program_q.push_back(itype(8, 2, 3'b010, 4, LOAD_OPC));
        program_q.push_back(rtype(7'b0000000, 5, 4, 3'b000, 3));
        program_q.push_back(EBREAK_INST);
        load_program();
        run_program();
        check_word("store load", data + 32'h123, gp_value);
    endtask

    task automatic control_flow();
        program_q.delete();
        program_q.push_back(addi(3, 0, 1));
        program_q.push_back(addi(1, 0, 5));
        program_q.push_back(addi(2, 0, 5));
        program_q.push_back(btype(12, 1, 2, 3'b000));
        program_q.push_back(addi(3, 3, 100));
        program_q.push_back(addi(3, 3, 200));
        program_q.push_back(addi(3, 3, 2));
        program_q.push_back(addi(4, 0, -3));
        program_q.push_back(btype(12, 4, 1, 3'b100));
        program_q.push_back(addi(3, 3, 100));
        program_q.push_back(addi(3, 3, 200));
        program_q.push_back(btype(8, 1, 2, 3'b001));
        program_q.push_back(addi(3, 3, 4));
        // jal at 52 links 56 into x6
        program_q.push_back(jtype(12, 6));
        program_q.push_back(addi(3, 3, 100));
        program_q.push_back(addi(3, 3, 200));
        program_q.push_back(rtype(7'b0000000, 6, 3, 3'b000, 3));
        program_q.push_back(jtype(16, 7));
        program_q.push_back(addi(3, 3, 8));
        program_q.push_back(EBREAK_INST);
        program_q.push_back(addi(3, 3, 100));
        program_q.push_back(addi(3, 3, 16));
        program_q.push_back(itype(0, 7, 3'b000, 0, JALR_OPC));
        program_q.push_back(addi(3, 3, 100));
        program_q.push_back(addi(3, 3, 200));
        load_program();
        run_program();
        check_word("control flow", 32'd1 + 32'd2 + 32'd4 + 32'd56 + 32'd16 + 32'd8, gp_value);
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        rng       = 32'hadb6;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        busy_control();
        alu_chain();
        lui_constant();
        store_load();
        control_flow();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
